//--- src/store_pkg.sv
// --------------------
// Widths, size codes and buffer geometry shared by the store path
// Memory is big-endian and word addressed with 32-bit data only
// Buffer depth must be a power of two and one slot always stays free
// --------------------
`default_nettype none

package store_pkg;

   // --------------------
   // Data path
   // --------------------
   typedef logic [31:0] data_t;

   // Byte address with the two low bits dropped
   typedef logic [29:0] word_addr_t;

   // Bit 3 enables the most significant byte
   typedef logic [3:0]  byte_en_t;

   // Store size as decoded from the opcode
   typedef logic [1:0]  size_t;

   localparam size_t SIZE_BYTE = 2'd0;
   localparam size_t SIZE_HALF = 2'd1;
   // Code 3 is handled as a word as well
   localparam size_t SIZE_WORD = 2'd2;

   // Step back one instruction for a store in a delay slot
   localparam int unsigned INSTR_BYTES = 4;

   // --------------------
   // Store buffer
   // --------------------
   localparam int unsigned SB_PTR_BITS = 3;
   localparam int unsigned SB_DEPTH    = 1 << SB_PTR_BITS;

   typedef logic [SB_PTR_BITS-1:0] sb_ptr_t;

endpackage

`default_nettype wire

//--- src/store_formatter.sv
// --------------------
// Formats one store per store_valid strobe and pushes it to the buffer
// Unaligned addresses are not trapped, the low bits simply pick lanes
// A refused store gives a single-cycle restart on the next cycle
// --------------------
`timescale 1ns/1ps
`default_nettype none

module store_formatter (
   input  logic                  clock,
   input  logic                  reset,

   // Execute stage
   input  logic                  store_valid,
   input  logic [31:0]           store_address,
   input  store_pkg::size_t      store_size,
   input  store_pkg::data_t      store_value,
   input  logic [31:0]           store_pc,
   input  logic                  store_delay_slot,

   // Store buffer
   input  logic                  full,
   output logic                  push,
   output store_pkg::word_addr_t push_address,
   output store_pkg::data_t      push_data,
   output store_pkg::byte_en_t   push_byte_en,

   // Pipeline restart
   output logic                  restart,
   output logic [31:0]           restart_pc
);

   // Store seen while the buffer has no room
   logic refused;

   // --------------------
   // Lane formatting
   // --------------------

   // Memory is word addressed
   assign push_address = store_address[31:2];

   // Replicate narrow data across all lanes so any lane can be written
   always_comb begin
      case (store_size)
         store_pkg::SIZE_BYTE: push_data = {4{store_value[7:0]}};
         store_pkg::SIZE_HALF: push_data = {2{store_value[15:0]}};
         default:              push_data = store_value;
      endcase
   end

   // Big-endian lanes, offset 0 is the top byte
   always_comb begin
      case (store_size)
         store_pkg::SIZE_BYTE: push_byte_en = 4'b1000 >> store_address[1:0];
         store_pkg::SIZE_HALF: push_byte_en = {{2{~store_address[1]}}, {2{store_address[1]}}};
         default:              push_byte_en = 4'b1111;
      endcase
   end

   // --------------------
   // Push or restart
   // --------------------

   // Entry is written at the edge that ends the strobe cycle
   assign push    = store_valid & ~full;
   assign refused = store_valid & full;

   // One-shot restart, drops again unless the next store is refused too
   always_ff @(posedge clock) begin
      if (reset) begin
         restart <= 1'b0;
      end else begin
         restart <= refused;
      end
   end

   // Re-execute the branch when the store sat in its delay slot
   always_ff @(posedge clock) begin
      if (refused) begin
         restart_pc <= store_pc - (store_delay_slot ? 32'(store_pkg::INSTR_BYTES) : 32'd0);
      end
   end

   // Buffer fills only through a push from this side
   a_full_after_push: assert property (
      @(posedge clock) disable iff (reset)
      $rose(full) |-> $past(push)
   );

endmodule

`default_nettype wire

//--- src/store_buffer.sv
// --------------------
// Circular buffer of formatted stores between formatter and writer
// Holds SB_DEPTH-1 entries since one slot separates full from empty
// Head outputs are only meaningful while empty is low
// --------------------
`timescale 1ns/1ps
`default_nettype none

module store_buffer (
   input  logic                  clock,
   input  logic                  reset,

   // Write side from the formatter
   input  logic                  push,
   input  store_pkg::word_addr_t push_address,
   input  store_pkg::data_t      push_data,
   input  store_pkg::byte_en_t   push_byte_en,

   // Read side to the memory writer
   input  logic                  pop,
   output store_pkg::word_addr_t head_address,
   output store_pkg::data_t      head_data,
   output store_pkg::byte_en_t   head_byte_en,

   // Levels
   output logic                  full,
   output logic                  empty
);

   // Entry storage, no reset needed on payload
   store_pkg::word_addr_t addr_mem [store_pkg::SB_DEPTH];
   store_pkg::data_t      data_mem [store_pkg::SB_DEPTH];
   store_pkg::byte_en_t   be_mem   [store_pkg::SB_DEPTH];

   // Pointers wrap naturally at the slot count
   store_pkg::sb_ptr_t    wr_ptr;
   store_pkg::sb_ptr_t    rd_ptr;
   store_pkg::sb_ptr_t    wr_ptr_next;
   store_pkg::sb_ptr_t    rd_ptr_next;

   assign wr_ptr_next = wr_ptr + store_pkg::sb_ptr_t'(1);
   assign rd_ptr_next = rd_ptr + store_pkg::sb_ptr_t'(1);

   // --------------------
   // Levels
   // --------------------

   // Full one slot early
   assign full  = (wr_ptr_next == rd_ptr);
   assign empty = (wr_ptr == rd_ptr);

   // Oldest entry
   assign head_address = addr_mem[rd_ptr];
   assign head_data    = data_mem[rd_ptr];
   assign head_byte_en = be_mem[rd_ptr];

   // --------------------
   // Pointer update
   // --------------------
   always_ff @(posedge clock) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr_next;
         end
         if (pop) begin
            rd_ptr <= rd_ptr_next;
         end
      end
   end

   // Write slot at the push edge
   always_ff @(posedge clock) begin
      if (push) begin
         addr_mem[wr_ptr] <= push_address;
         data_mem[wr_ptr] <= push_data;
         be_mem[wr_ptr]   <= push_byte_en;
      end
   end

   // Formatter must honour full
   a_no_push_full: assert property (
      @(posedge clock) disable iff (reset) push |-> !full
   );

   // Writer must honour empty
   a_no_pop_empty: assert property (
      @(posedge clock) disable iff (reset) pop |-> !empty
   );

endmodule

`default_nettype wire

//--- src/dmem_writer.sv
// --------------------
// Drains the store buffer into main memory one store per cycle
// All memory outputs are registered and hold while waitrequest is high
// No reads are issued, this port writes only
// --------------------
`timescale 1ns/1ps
`default_nettype none

module dmem_writer (
   input  logic                  clock,
   input  logic                  reset,

   // Store buffer head
   input  logic                  empty,
   input  store_pkg::word_addr_t head_address,
   input  store_pkg::data_t      head_data,
   input  store_pkg::byte_en_t   head_byte_en,
   output logic                  pop,

   // Main memory write port
   input  logic                  dmem_waitrequest,
   output logic                  dmem_write,
   output store_pkg::word_addr_t dmem_address,
   output store_pkg::data_t      dmem_writedata,
   output store_pkg::byte_en_t   dmem_writedatamask
);

   // Take the head whenever the port is free to reload
   assign pop = ~dmem_waitrequest & ~empty;

   // --------------------
   // Write request
   // --------------------

   // Request level, reloaded only while memory is not stalling
   always_ff @(posedge clock) begin
      if (reset) begin
         dmem_write <= 1'b0;
      end else if (!dmem_waitrequest) begin
         dmem_write <= ~empty;
      end
   end

   // Payload follows the popped entry
   always_ff @(posedge clock) begin
      if (pop) begin
         dmem_address       <= head_address;
         dmem_writedata     <= head_data;
         dmem_writedatamask <= head_byte_en;
      end
   end

   // Head must stay put until this side pops it
   a_head_stable: assert property (
      @(posedge clock) disable iff (reset)
      !empty && !pop |=>
         !empty && $stable(head_address) &&
         $stable(head_data) && $stable(head_byte_en)
   );

endmodule

`default_nettype wire

//--- src/store_path_top.sv
// --------------------
// Write-through store path of the memory stage
// Every address goes through the buffer, there is no peripheral bypass
// Store to memory write takes two edges when idle and unstalled
// --------------------
`timescale 1ns/1ps
`default_nettype none

module store_path_top (
   input  logic                  clock,
   input  logic                  reset,

   // Execute stage
   input  logic                  store_valid,
   input  logic [31:0]           store_address,
   input  store_pkg::size_t      store_size,
   input  store_pkg::data_t      store_value,
   input  logic [31:0]           store_pc,
   input  logic                  store_delay_slot,

   // Pipeline restart
   output logic                  restart,
   output logic [31:0]           restart_pc,

   // Main memory
   input  logic                  dmem_waitrequest,
   output logic                  dmem_write,
   output store_pkg::word_addr_t dmem_address,
   output store_pkg::data_t      dmem_writedata,
   output store_pkg::byte_en_t   dmem_writedatamask
);

   // --------------------
   // Formatter to buffer
   // --------------------
   logic                  push;
   store_pkg::word_addr_t push_address;
   store_pkg::data_t      push_data;
   store_pkg::byte_en_t   push_byte_en;
   logic                  full;

   // Buffer to writer
   logic                  pop;
   logic                  empty;
   store_pkg::word_addr_t head_address;
   store_pkg::data_t      head_data;
   store_pkg::byte_en_t   head_byte_en;

   // Producer
   store_formatter i_store_formatter (
      .clock, .reset,
      .store_valid, .store_address, .store_size, .store_value,
      .store_pc, .store_delay_slot,
      .full, .push, .push_address, .push_data, .push_byte_en,
      .restart, .restart_pc
   );

   // Queue
   store_buffer i_store_buffer (
      .clock, .reset,
      .push, .push_address, .push_data, .push_byte_en,
      .pop, .head_address, .head_data, .head_byte_en,
      .full, .empty
   );

   // Consumer
   dmem_writer i_dmem_writer (
      .clock, .reset,
      .empty, .head_address, .head_data, .head_byte_en, .pop,
      .dmem_waitrequest, .dmem_write, .dmem_address,
      .dmem_writedata, .dmem_writedatamask
   );

endmodule

`default_nettype wire

//--- sim/store_path_tb.sv
// --------------------
// Directed testbench for the store path top level
// Expected writes come from a format model and a buffer occupancy model
// Stops at the first mismatch, a watchdog bounds the run
// --------------------
`timescale 1ns/1ps
`default_nettype none

module store_path_tb;

   localparam int CLOCK_PERIOD = 20;
   localparam int RESET_CYCLES = 5;
   localparam int BUFFER_SLOTS = int'(store_pkg::SB_DEPTH) - 1;
   localparam int DRAIN_LIMIT  = 100;

   // Rough cycle budget per test
   localparam int FORMAT_CYCLES   = 9 * 8;
   localparam int ORDER_CYCLES    = 40;
   localparam int FULL_CYCLES     = 40;
   localparam int RANDOM_STORES   = 200;
   localparam int RANDOM_CYCLES   = RANDOM_STORES * 4;
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + FORMAT_CYCLES + ORDER_CYCLES +
                                    FULL_CYCLES + RANDOM_CYCLES + 200;

   logic                  clock;
   logic                  reset;
   logic                  store_valid;
   logic [31:0]           store_address;
   store_pkg::size_t      store_size;
   store_pkg::data_t      store_value;
   logic [31:0]           store_pc;
   logic                  store_delay_slot;
   logic                  restart;
   logic [31:0]           restart_pc;
   logic                  dmem_waitrequest;
   logic                  dmem_write;
   store_pkg::word_addr_t dmem_address;
   store_pkg::data_t      dmem_writedata;
   store_pkg::byte_en_t   dmem_writedatamask;

   // Reference queue of writes still owed by the DUT
   store_pkg::word_addr_t exp_addr_q [$];
   store_pkg::data_t      exp_data_q [$];
   store_pkg::byte_en_t   exp_be_q [$];

   // Buffer occupancy model and pending restart
   int                    model_count;
   logic                  refuse_pending;
   logic [31:0]           refuse_pc;

   // Last stalled write, for the hold check
   logic                  held;
   store_pkg::word_addr_t held_addr;
   store_pkg::data_t      held_data;
   store_pkg::byte_en_t   held_mask;

   string                 test_name = "init";
   integer                seed = 32'h1453_f81f;

   store_path_top i_store_path_top (
      .clock, .reset,
      .store_valid, .store_address, .store_size, .store_value,
      .store_pc, .store_delay_slot,
      .restart, .restart_pc,
      .dmem_waitrequest, .dmem_write, .dmem_address,
      .dmem_writedata, .dmem_writedatamask
   );

   initial begin
      clock = 1'b0;
      forever #(CLOCK_PERIOD / 2) clock = ~clock;
   end

   // --------------------
   // Checks
   // --------------------
   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic check_bit(input string what, input logic expected, input logic actual);
      if (actual !== expected) begin
         stop_on_error($sformatf("Fail %s: %s expected %b, actual %b",
                                 test_name, what, expected, actual));
      end
   endtask

   task automatic check_word_addr(input string what, input store_pkg::word_addr_t expected,
                                  input store_pkg::word_addr_t actual);
      if (actual !== expected) begin
         stop_on_error($sformatf("Fail %s: %s expected %h, actual %h",
                                 test_name, what, expected, actual));
      end
   endtask

   task automatic check_data(input string what, input store_pkg::data_t expected,
                             input store_pkg::data_t actual);
      if (actual !== expected) begin
         stop_on_error($sformatf("Fail %s: %s expected %h, actual %h",
                                 test_name, what, expected, actual));
      end
   endtask

   task automatic check_byte_en(input string what, input store_pkg::byte_en_t expected,
                                input store_pkg::byte_en_t actual);
      if (actual !== expected) begin
         stop_on_error($sformatf("Fail %s: %s expected %b, actual %b",
                                 test_name, what, expected, actual));
      end
   endtask

   // --------------------
   // Format model
   // --------------------
   task automatic format_store(input logic [31:0] address, input store_pkg::size_t size,
                               input store_pkg::data_t value,
                               output store_pkg::word_addr_t e_addr,
                               output store_pkg::data_t e_data,
                               output store_pkg::byte_en_t e_be);
      int lane;
      e_addr = address[31:2];
      e_be   = 4'b0000;
      if (size == store_pkg::SIZE_BYTE) begin
         for (int k = 0; k < 4; k++) begin
            e_data[8*k +: 8] = value[7:0];
         end
         // Offset 0 is the top byte
         lane = 3 - int'(address[1:0]);
         e_be[lane] = 1'b1;
      end else if (size == store_pkg::SIZE_HALF) begin
         e_data = {value[15:0], value[15:0]};
         e_be   = address[1] ? 4'b0011 : 4'b1100;
      end else begin
         e_data = value;
         e_be   = 4'b1111;
      end
   endtask

   // Memory side and model, all sampled on the rising edge
   always @(posedge clock) begin : memory_model
      logic                  push_m;
      logic                  pop_m;
      store_pkg::word_addr_t f_addr;
      store_pkg::data_t      f_data;
      store_pkg::byte_en_t   f_be;
      if (reset) begin
         model_count    = 0;
         refuse_pending = 1'b0;
         held           = 1'b0;
      end else begin
         check_bit("restart", refuse_pending, restart);
         if (refuse_pending) begin
            check_data("restart_pc", refuse_pc, restart_pc);
         end
         // Stalled write must come back unchanged
         if (held) begin
            check_bit("held dmem_write", 1'b1, dmem_write);
            check_word_addr("held dmem_address", held_addr, dmem_address);
            check_data("held dmem_writedata", held_data, dmem_writedata);
            check_byte_en("held dmem_writedatamask", held_mask, dmem_writedatamask);
         end
         held      = dmem_write & dmem_waitrequest;
         held_addr = dmem_address;
         held_data = dmem_writedata;
         held_mask = dmem_writedatamask;
         // Accepted write against the oldest owed store
         if (dmem_write && !dmem_waitrequest) begin
            if (exp_addr_q.size() == 0) begin
               stop_on_error($sformatf("%s: memory accepted a write that no store produced",
                                       test_name));
            end
            check_word_addr("dmem_address", exp_addr_q.pop_front(), dmem_address);
            check_data("dmem_writedata", exp_data_q.pop_front(), dmem_writedata);
            check_byte_en("dmem_writedatamask", exp_be_q.pop_front(), dmem_writedatamask);
         end
         // Seven entries at most, the writer pops whenever unstalled
         push_m = store_valid && (model_count != BUFFER_SLOTS);
         pop_m  = !dmem_waitrequest && (model_count != 0);
         refuse_pending = store_valid && !push_m;
         refuse_pc      = store_delay_slot ? store_pc - 32'd4 : store_pc;
         if (push_m) begin
            format_store(store_address, store_size, store_value, f_addr, f_data, f_be);
            exp_addr_q.push_back(f_addr);
            exp_data_q.push_back(f_data);
            exp_be_q.push_back(f_be);
         end
         model_count = model_count + int'(push_m) - int'(pop_m);
      end
   end

   // --------------------
   // Stimulus
   // --------------------
   task automatic drive_store(input logic [31:0] address, input store_pkg::size_t size,
                              input store_pkg::data_t value, input logic [31:0] pc,
                              input logic delay_slot);
      store_address    = address;
      store_size       = size;
      store_value      = value;
      store_pc         = pc;
      store_delay_slot = delay_slot;
      store_valid      = 1'b1;
   endtask

   // One-cycle strobe, returns just after the push edge
   task automatic issue_store(input logic [31:0] address, input store_pkg::size_t size,
                              input store_pkg::data_t value, input logic [31:0] pc,
                              input logic delay_slot);
      drive_store(address, size, value, pc, delay_slot);
      @(posedge clock);
      #2;
      store_valid = 1'b0;
   endtask

   // Mode 0 unstalled, 1 toggling, 2 random waitrequest
   task automatic drain(input int mode);
      int          cycles;
      logic [31:0] r;
      cycles = 0;
      while (exp_addr_q.size() != 0) begin
         if (cycles == DRAIN_LIMIT) begin
            stop_on_error($sformatf("%s: stores still pending after %0d cycles",
                                    test_name, DRAIN_LIMIT));
         end
         r = $random(seed);
         case (mode)
            0:       dmem_waitrequest = 1'b0;
            1:       dmem_waitrequest = cycles[0];
            default: dmem_waitrequest = r[0];
         endcase
         @(posedge clock);
         #2;
         cycles++;
      end
      dmem_waitrequest = 1'b0;
   endtask

   // --------------------
   // Tests
   // --------------------
   task automatic test_reset();
      test_name = "test_reset";
      check_bit("dmem_write", 1'b0, dmem_write);
      check_bit("restart", 1'b0, restart);
   endtask

   task automatic format_case(input logic [31:0] address, input store_pkg::size_t size,
                              input store_pkg::data_t value);
      issue_store(address, size, value, 32'h0000_0100, 1'b0);
      // Writer loads the entry on the edge after the push edge
      @(posedge clock);
      #2;
      check_bit("dmem_write one cycle after push", 1'b1, dmem_write);
      drain(0);
   endtask

   task automatic test_formats();
      test_name = "test_formats";
      dmem_waitrequest = 1'b0;
      for (int k = 0; k < 4; k++) begin
         format_case(32'h0000_1000 + 32'(k), store_pkg::SIZE_BYTE, 32'h1234_5600 + 32'(k * 17));
      end
      format_case(32'h0000_2000, store_pkg::SIZE_HALF, 32'hDEAD_BEEF);
      format_case(32'h0000_2002, store_pkg::SIZE_HALF, 32'h0BAD_F00D);
      format_case(32'h0000_2003, store_pkg::SIZE_HALF, 32'h5A5A_C3C3);
      format_case(32'h0000_3000, store_pkg::SIZE_WORD, 32'h8765_4321);
      format_case(32'h0000_3004, 2'd3, 32'h0F1E_2D3C);
   endtask

   task automatic test_order();
      test_name = "test_order";
      dmem_waitrequest = 1'b1;
      for (int i = 0; i < 5; i++) begin
         issue_store(32'h0000_4000 + 32'(4 * i), store_pkg::SIZE_WORD,
                     32'hA000_0000 + 32'(i), 32'h0000_0200, 1'b0);
      end
      repeat (3) @(posedge clock);
      #2;
      check_bit("dmem_write while stalled from idle", 1'b0, dmem_write);
      drain(1);
   endtask

   task automatic test_full_restart();
      test_name = "test_full_restart";
      dmem_waitrequest = 1'b1;
      for (int i = 0; i < 7; i++) begin
         issue_store(32'h0000_5000 + 32'(4 * i), store_pkg::SIZE_WORD,
                     32'hB000_0000 + 32'(i), 32'h0000_2000 + 32'(4 * i), 1'b0);
      end
      // Eighth store sits in a delay slot
      issue_store(32'h0000_5020, store_pkg::SIZE_WORD, 32'hB000_0007, 32'h0000_2040, 1'b1);
      check_bit("restart after eighth store", 1'b1, restart);
      check_data("restart_pc for delay slot", 32'h0000_203C, restart_pc);
      @(posedge clock);
      #2;
      check_bit("restart one cycle only", 1'b0, restart);
      issue_store(32'h0000_5024, store_pkg::SIZE_WORD, 32'hB000_0008, 32'h0000_2044, 1'b0);
      check_bit("restart after ninth store", 1'b1, restart);
      check_data("restart_pc", 32'h0000_2044, restart_pc);
      @(posedge clock);
      #2;
      check_bit("restart one cycle only", 1'b0, restart);
      drain(0);
      repeat (3) @(posedge clock);
      #2;
      // Refused stores leave nothing behind for the writer
      check_bit("dmem_write after seven writes", 1'b0, dmem_write);
   endtask

   task automatic test_random();
      logic [31:0] r;
      logic [31:0] address;
      logic [31:0] value;
      logic [31:0] pc;
      int          sent;
      test_name = "test_random";
      sent = 0;
      // Issue rate above drain rate so the buffer fills now and then
      while (sent < RANDOM_STORES) begin
         r       = $random(seed);
         address = $random(seed);
         value   = $random(seed);
         pc      = $random(seed);
         dmem_waitrequest = r[0];
         if (r[2:1] != 2'b00) begin
            drive_store(address, r[4:3], value, {pc[31:2], 2'b00}, r[5]);
            sent++;
         end else begin
            store_valid = 1'b0;
         end
         @(posedge clock);
         #2;
      end
      store_valid = 1'b0;
      drain(2);
   endtask

   // Watchdog
   initial begin
      #(WATCHDOG_CYCLES * CLOCK_PERIOD);
      stop_on_error("Watchdog expired before the tests finished");
   end

   initial begin
      reset            = 1'b1;
      store_valid      = 1'b0;
      store_address    = 32'h0;
      store_size       = store_pkg::SIZE_WORD;
      store_value      = 32'h0;
      store_pc         = 32'h0;
      store_delay_slot = 1'b0;
      dmem_waitrequest = 1'b0;
      repeat (RESET_CYCLES) @(posedge clock);
      #2;
      reset = 1'b0;
      test_reset();
      test_formats();
      test_order();
      test_full_restart();
      test_random();
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- store_path.f
src/store_pkg.sv
src/store_formatter.sv
src/store_buffer.sv
src/dmem_writer.sv
src/store_path_top.sv
sim/store_path_tb.sv

//--- Makefile
# Verilator flow for the store path

RTL = src/store_pkg.sv src/store_formatter.sv src/store_buffer.sv \
      src/dmem_writer.sv src/store_path_top.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only --top-module store_path_top $(RTL)

sim:
	verilator --binary --timing --assert -j 0 --top-module store_path_tb \
		-f store_path.f -o store_path_sim
	./obj_dir/store_path_sim > sim.log 2>&1 || true
	cat sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
